// ==== common/ramio_pkg.sv ====
/*
  ramio package
  bus types and the i/o address map of the load/store port
*/
package ramio_pkg;

  // client byte address
  typedef logic [31:0] addr_t;

  // client data word
  typedef logic [31:0] data_t;

  // one byte lane of a word
  typedef logic [7:0] byte_t;

  // 0 no read; [1:0] size 01 byte, 10 half, 11 word; [2] sign extend
  typedef logic [2:0] read_type_t;

  // 0 no write; same size encoding as reads
  typedef logic [1:0] write_type_t;

  // led state, 0 is on and 1 is off
  typedef logic [3:0] led_t;

  // led register in the low nibble
  localparam addr_t ADDR_LED = 32'hffff_fffc;

  // uart transmit, reads back the byte in flight
  localparam addr_t ADDR_UART_OUT = 32'hffff_fff8;

  // uart receive, cleared to idle once read
  localparam addr_t ADDR_UART_IN = 32'hffff_fff4;

  // returned by a uart register that holds nothing
  localparam data_t IO_IDLE = 32'hffff_ffff;

endpackage

// ==== ramio/ram_bank.sv ====
/*
  ram bank
  one byte lane of the word ram, synchronous write and registered read
*/
module ram_bank import ramio_pkg::*; #(
  parameter int ADDR_W = 8
) (
  input  logic              clk,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  byte_t             wdata_i,
  output byte_t             rdata_o
);

  // one lane of every word
  byte_t mem [2**ADDR_W];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[addr_i] <= wdata_i;
    end
    // read returns the old contents on a same-cycle write
    rdata_o <= mem[addr_i];
  end

endmodule

// ==== ramio/ramio.sv ====
/*
  ramio
  load/store port: decodes i/o addresses, steers writes onto byte lanes,
  extracts and extends read data, holds the led and uart registers
*/
module ramio import ramio_pkg::*; #(
  parameter int RAM_ADDR_W = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_i,
  input  addr_t                 addr_i,
  input  read_type_t            read_type_i,
  input  write_type_t           write_type_i,
  input  data_t                 wdata_i,
  output data_t                 rdata_o,
  output logic                  rvalid_o,
  output logic [RAM_ADDR_W-1:0] bank_addr_o,
  output logic [3:0]            bank_we_o,
  output byte_t [3:0]           bank_wdata_o,
  input  byte_t [3:0]           bank_rdata_i,
  output led_t                  led_o,
  output logic                  tx_start_o,
  output byte_t                 tx_data_o,
  input  logic                  tx_busy_i,
  input  logic                  rx_valid_i,
  input  byte_t                 rx_data_i
);

  logic is_led;
  logic is_uout;
  logic is_uin;
  logic is_io;
  logic rd_req;
  logic wr_req;
  // transmitter counts as busy from the accepted write until its frame ends
  logic tx_active;
  logic tx_accept;
  data_t io_word;
  data_t rx_reg;

  // request state held for the response cycle
  read_type_t rd_type_q;
  logic [1:0] rd_off_q;
  logic       rd_io_q;
  data_t      io_rdata_q;

  data_t       rd_word;
  byte_t       rd_lane;
  logic [15:0] rd_half;

  assign is_led  = addr_i == ADDR_LED;
  assign is_uout = addr_i == ADDR_UART_OUT;
  assign is_uin  = addr_i == ADDR_UART_IN;
  assign is_io   = is_led | is_uout | is_uin;

  assign rd_req = req_i && read_type_i != '0;
  assign wr_req = req_i && write_type_i != '0;

  // start strobe covers the cycle before uart_tx raises busy
  assign tx_active = tx_start_o | tx_busy_i;
  assign tx_accept = wr_req && is_uout && !tx_active;

  // word address, lane select lives in addr bits 1:0
  assign bank_addr_o = addr_i[RAM_ADDR_W+1:2];

  // replicate data over the lanes, enables pick the ones to write
  always_comb begin
    bank_we_o    = '0;
    bank_wdata_o = wdata_i;
    case (write_type_i)
      2'b01: begin
        bank_wdata_o = {4{wdata_i[7:0]}};
        bank_we_o    = 4'b0001 << addr_i[1:0];
      end
      2'b10: begin
        bank_wdata_o = {2{wdata_i[15:0]}};
        bank_we_o    = addr_i[1] ? 4'b1100 : 4'b0011;
      end
      2'b11: bank_we_o = 4'b1111;
      default: bank_we_o = '0;
    endcase
    // i/o writes never reach the ram
    if (!req_i || is_io) begin
      bank_we_o = '0;
    end
  end

  // i/o read value, sampled with the request
  always_comb begin
    io_word = {28'b0, led_o};
    if (is_uout) begin
      io_word = tx_active ? {24'b0, tx_data_o} : IO_IDLE;
    end else if (is_uin) begin
      io_word = rx_reg;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rvalid_o   <= 1'b0;
      led_o      <= '1;
      tx_start_o <= 1'b0;
      rx_reg     <= IO_IDLE;
    end else begin
      rvalid_o   <= rd_req;
      tx_start_o <= tx_accept;
      if (wr_req && is_led) begin
        led_o <= wdata_i[3:0];
      end
      // a fresh byte wins over the clear of a same-cycle read
      if (rx_valid_i) begin
        rx_reg <= {24'b0, rx_data_i};
      end else if (rd_req && is_uin) begin
        rx_reg <= IO_IDLE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tx_accept) begin
      tx_data_o <= wdata_i[7:0];
    end
    if (rd_req) begin
      rd_type_q  <= read_type_i;
      rd_off_q   <= addr_i[1:0];
      rd_io_q    <= is_io;
      io_rdata_q <= io_word;
    end
  end

  // banks return their lanes one cycle after the request
  assign rd_word = bank_rdata_i;
  assign rd_lane = bank_rdata_i[rd_off_q];
  assign rd_half = rd_off_q[1] ? rd_word[31:16] : rd_word[15:0];

  always_comb begin
    case (rd_type_q[1:0])
      2'b01:   rdata_o = {{24{rd_type_q[2] & rd_lane[7]}}, rd_lane};
      2'b10:   rdata_o = {{16{rd_type_q[2] & rd_half[15]}}, rd_half};
      default: rdata_o = rd_word;
    endcase
    if (rd_io_q) begin
      rdata_o = io_rdata_q;
    end
  end

  // half words sit on even addresses
  a_half_align: assert property (@(posedge clk) disable iff (!rst_n)
    req_i && (read_type_i[1:0] == 2'b10 || write_type_i == 2'b10) |-> !addr_i[0]);

  // words sit on word boundaries
  a_word_align: assert property (@(posedge clk) disable iff (!rst_n)
    req_i && (read_type_i[1:0] == 2'b11 || write_type_i == 2'b11) |-> addr_i[1:0] == 2'b00);

  a_rd_or_wr: assert property (@(posedge clk) disable iff (!rst_n)
    req_i |-> !(read_type_i != '0 && write_type_i != '0));

endmodule

// ==== verilog/uart_tx.sv ====
/*
  uart transmitter
  8n1 frames, lsb first, one bit every CLKS_PER_BIT cycles
*/
module uart_tx import ramio_pkg::*; #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  start_i,
  input  byte_t data_i,
  output logic  busy_o,
  output logic  tx_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

  tx_state_t        state;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;
  byte_t            shift;
  logic             bit_end;

  // last cycle of the current bit
  assign bit_end = cnt == CNT_W'(CLKS_PER_BIT - 1);
  assign busy_o  = state != TX_IDLE;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= TX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      tx_o    <= 1'b1;
    end else begin
      cnt <= bit_end || state == TX_IDLE ? '0 : cnt + 1'b1;
      case (state)
        TX_IDLE: if (start_i) begin
          state <= TX_START;
          tx_o  <= 1'b0;
          shift <= data_i;
        end
        TX_START: if (bit_end) begin
          state   <= TX_DATA;
          bit_idx <= '0;
          tx_o    <= shift[0];
          shift   <= shift >> 1;
        end
        TX_DATA: if (bit_end) begin
          if (bit_idx == 3'd7) begin
            state <= TX_STOP;
            tx_o  <= 1'b1;
          end else begin
            bit_idx <= bit_idx + 1'b1;
            tx_o    <= shift[0];
            shift   <= shift >> 1;
          end
        end
        default: if (bit_end) begin
          state <= TX_IDLE;
        end
      endcase
    end
  end

  // ramio must hold off until the frame is done
  a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
    start_i |-> !busy_o);

endmodule

// ==== verilog/uart_rx.sv ====
/*
  uart receiver
  8n1 frames, start edge detect, samples every bit at its middle
*/
module uart_rx import ramio_pkg::*; #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  rx_i,
  output logic  valid_o,
  output byte_t data_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam int HALF  = CLKS_PER_BIT / 2;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t        state;
  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;
  logic             bit_end;
  logic             half_end;

  assign bit_end  = cnt == CNT_W'(CLKS_PER_BIT - 1);
  assign half_end = cnt == CNT_W'(HALF - 1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
      state   <= RX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      valid_o <= 1'b0;
    end else begin
      // two flop synchronizer, then one more for the edge
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
      valid_o <= 1'b0;
      cnt     <= cnt + 1'b1;
      case (state)
        RX_IDLE: begin
          cnt <= '0;
          if (rx_prev && !rx_sync) begin
            state <= RX_START;
          end
        end
        // recheck start at half a bit, a glitch goes back to idle
        RX_START: if (half_end) begin
          cnt     <= '0;
          bit_idx <= '0;
          state   <= rx_sync ? RX_IDLE : RX_DATA;
        end
        // from here on each bit_end lands mid-bit
        RX_DATA: if (bit_end) begin
          cnt    <= '0;
          data_o <= {rx_sync, data_o[7:1]};
          if (bit_idx == 3'd7) begin
            state <= RX_STOP;
          end else begin
            bit_idx <= bit_idx + 1'b1;
          end
        end
        default: if (bit_end) begin
          // low stop bit is a framing error, byte dropped
          valid_o <= rx_sync;
          state   <= RX_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== verilog/ramio_top.sv ====
/*
  ramio top
  load/store port with four byte-lane ram banks and an 8n1 uart
*/
module ramio_top import ramio_pkg::*; #(
  parameter int RAM_ADDR_W   = 8,
  parameter int CLKS_PER_BIT = 8
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,
  input  addr_t       addr_i,
  input  read_type_t  read_type_i,
  input  write_type_t write_type_i,
  input  data_t       wdata_i,
  output data_t       rdata_o,
  output logic        rvalid_o,
  output led_t        led_o,
  output logic        uart_tx_o,
  input  logic        uart_rx_i
);

  logic [RAM_ADDR_W-1:0] bank_addr;
  logic [3:0]            bank_we;
  byte_t [3:0]           bank_wdata;
  byte_t [3:0]           bank_rdata;
  logic                  tx_start;
  byte_t                 tx_data;
  logic                  tx_busy;
  logic                  rx_valid;
  byte_t                 rx_data;

  ramio #(.RAM_ADDR_W(RAM_ADDR_W)) u_ramio (
    .clk, .rst_n, .req_i, .addr_i, .read_type_i, .write_type_i, .wdata_i,
    .rdata_o, .rvalid_o,
    .bank_addr_o(bank_addr), .bank_we_o(bank_we),
    .bank_wdata_o(bank_wdata), .bank_rdata_i(bank_rdata),
    .led_o,
    .tx_start_o(tx_start), .tx_data_o(tx_data), .tx_busy_i(tx_busy),
    .rx_valid_i(rx_valid), .rx_data_i(rx_data)
  );

  // lane g holds byte g of every word
  for (genvar g = 0; g < 4; g++) begin : g_bank
    ram_bank #(.ADDR_W(RAM_ADDR_W)) u_bank (
      .clk, .we_i(bank_we[g]), .addr_i(bank_addr),
      .wdata_i(bank_wdata[g]), .rdata_o(bank_rdata[g])
    );
  end

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
    .clk, .rst_n, .start_i(tx_start), .data_i(tx_data),
    .busy_o(tx_busy), .tx_o(uart_tx_o)
  );

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
    .clk, .rst_n, .rx_i(uart_rx_i), .valid_o(rx_valid), .data_o(rx_data)
  );

endmodule

// ==== verification/tb_ramio.sv ====
/*
  ramio testbench
  table-driven load/store checks against a reference word array,
  the led register, and uart transmit and receive through a loopback
*/
module tb_ramio import ramio_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RAM_ADDR_W   = 8;
  localparam int CLKS_PER_BIT = 8;
  localparam int FRAME_CLKS   = 10 * CLKS_PER_BIT;
  localparam int POLL_MAX     = 2 * FRAME_CLKS;

  typedef enum int {OP_WR, OP_RD, OP_LED, OP_FRAME, OP_WAIT, OP_POLL} op_t;

  // one table row
  // for ram writes wdata is or-ed into the random word, for waits it is the cycle count
  typedef struct {
    op_t        op;
    addr_t      addr;
    read_type_t typ;
    data_t      wdata;
    data_t      exp;
  } entry_t;

  logic        clk;
  logic        rst_n;
  logic        req;
  addr_t       addr;
  read_type_t  rd_type;
  write_type_t wr_type;
  data_t       wdata;
  data_t       rdata;
  logic        rvalid;
  led_t        led;
  logic        uart_line;

  entry_t tbl[$];
  bit     tbl_ready;
  data_t  ref_mem [2**RAM_ADDR_W];
  data_t  lcg_state;
  int     err_cnt;
  int     pass_cnt;
  int     fail_cnt;

  // read issued last cycle, checked on the next falling edge
  logic  pend_rd;
  int    pend_idx;
  data_t pend_exp;
  string pend_desc;

  // transmitter drives the receiver directly
  ramio_top #(.RAM_ADDR_W(RAM_ADDR_W), .CLKS_PER_BIT(CLKS_PER_BIT)) DUT (
    .clk, .rst_n, .req_i(req), .addr_i(addr), .read_type_i(rd_type),
    .write_type_i(wr_type), .wdata_i(wdata), .rdata_o(rdata), .rvalid_o(rvalid),
    .led_o(led), .uart_tx_o(uart_line), .uart_rx_i(uart_line)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic data_t lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic is_io_addr(addr_t a);
    return a == ADDR_LED || a == ADDR_UART_OUT || a == ADDR_UART_IN;
  endfunction

  // byte goes to lane a[1:0], half word to lanes 0-1 or 2-3
  function automatic void ref_write(addr_t a, write_type_t wt, data_t d);
    data_t w;
    w = ref_mem[a[RAM_ADDR_W+1:2]];
    case (wt)
      2'b01: w[8*a[1:0] +: 8] = d[7:0];
      2'b10: w[16*a[1] +: 16] = d[15:0];
      2'b11: w = d;
      default: w = w;
    endcase
    ref_mem[a[RAM_ADDR_W+1:2]] = w;
  endfunction

  function automatic data_t ref_read(addr_t a, read_type_t rt);
    data_t       w;
    byte_t       b;
    logic [15:0] h;
    w = ref_mem[a[RAM_ADDR_W+1:2]];
    b = w[8*a[1:0] +: 8];
    h = w[16*a[1] +: 16];
    case (rt[1:0])
      2'b01:   return rt[2] ? {{24{b[7]}}, b} : {24'b0, b};
      2'b10:   return rt[2] ? {{16{h[15]}}, h} : {16'b0, h};
      default: return w;
    endcase
  endfunction

  task automatic check_data(string name, data_t got, data_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_led(string name, led_t got, led_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_test(int idx, string desc, int errs);
    if (err_cnt == errs) begin
      pass_cnt++;
      $display("test %0d %s: ok", idx, desc);
    end else begin
      fail_cnt++;
      $display("test %0d %s: wrong", idx, desc);
    end
  endtask

  task automatic idle_inputs();
    req     = 1'b0;
    addr    = '0;
    rd_type = '0;
    wr_type = '0;
    wdata   = '0;
  endtask

  task automatic drive_req(addr_t a, read_type_t rt, write_type_t wt, data_t d);
    req     = 1'b1;
    addr    = a;
    rd_type = rt;
    wr_type = wt;
    wdata   = d;
  endtask

  // rvalid must be high exactly in the cycle after a read strobe
  task automatic finish_pending();
    int errs;
    errs = err_cnt;
    if (pend_rd) begin
      if (rvalid !== 1'b1) begin
        err_cnt++;
        $display("test %0d: rvalid_o did not come one cycle after the read", pend_idx);
      end else begin
        check_data("rdata_o", rdata, pend_exp);
      end
      report_test(pend_idx, pend_desc, errs);
      pend_rd = 1'b0;
    end else if (rvalid !== 1'b0) begin
      err_cnt++;
      $display("rvalid_o pulsed without a read one cycle earlier");
    end
  endtask

  // starts inside the start bit, samples the line mid-bit, lsb first
  task automatic read_frame(output byte_t b, output logic framed);
    logic start_bit;
    repeat (CLKS_PER_BIT / 2) @(negedge clk);
    start_bit = uart_line;
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      b[i] = uart_line;
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    framed = !start_bit && uart_line;
  endtask

  task automatic poll_uart_in(int idx, data_t exp);
    int    errs;
    int    tries;
    logic  found;
    data_t got;
    errs  = err_cnt;
    found = 1'b0;
    tries = 0;
    got   = IO_IDLE;
    while (!found && tries < POLL_MAX) begin
      drive_req(ADDR_UART_IN, 3'b011, '0, '0);
      @(negedge clk);
      idle_inputs();
      tries++;
      if (rvalid !== 1'b1) begin
        err_cnt++;
        $display("test %0d: rvalid_o missing while polling the receive register", idx);
        tries = POLL_MAX;
      end else if (rdata !== IO_IDLE) begin
        found = 1'b1;
        got   = rdata;
      end
    end
    if (found) begin
      check_data("rdata_o", got, exp);
    end else if (err_cnt == errs) begin
      err_cnt++;
      $display("test %0d: no byte arrived at the receive register after %0d polls",
               idx, POLL_MAX);
    end
    report_test(idx, "poll uart in", errs);
  endtask

  task automatic run_entry(int idx);
    entry_t e;
    data_t  d;
    byte_t  b;
    logic   framed;
    int     errs;
    e = tbl[idx];
    @(negedge clk);
    finish_pending();
    idle_inputs();
    errs = err_cnt;
    case (e.op)
      OP_WR: begin
        d = e.wdata;
        if (!is_io_addr(e.addr)) begin
          d = lcg_next() | e.wdata;
          ref_write(e.addr, e.typ[1:0], d);
        end
        drive_req(e.addr, '0, e.typ[1:0], d);
        report_test(idx, $sformatf("write %h <- %h", e.addr, d), errs);
      end
      OP_RD: begin
        drive_req(e.addr, e.typ, '0, '0);
        pend_rd   = 1'b1;
        pend_idx  = idx;
        pend_exp  = is_io_addr(e.addr) ? e.exp : ref_read(e.addr, e.typ);
        pend_desc = $sformatf("read %h type %0d", e.addr, e.typ);
      end
      OP_LED: begin
        check_led("led_o", led, e.exp[3:0]);
        report_test(idx, "led", errs);
      end
      OP_FRAME: begin
        read_frame(b, framed);
        check_data("uart_tx_o", {24'b0, b}, e.exp);
        if (!framed) begin
          err_cnt++;
          $display("test %0d: uart_tx_o start or stop bit at the wrong level", idx);
        end
        report_test(idx, "uart frame", errs);
      end
      OP_WAIT: begin
        repeat (e.wdata) @(negedge clk);
        report_test(idx, $sformatf("wait %0d cycles", e.wdata), errs);
      end
      default: poll_uart_in(idx, e.exp);
    endcase
  endtask

  task automatic add_row(op_t op, addr_t a, read_type_t t, data_t wd, data_t ex);
    tbl.push_back('{op, a, t, wd, ex});
  endtask

  task automatic build_table();
    // nothing sent yet, receive register idle
    add_row(OP_RD, ADDR_UART_IN, 3'b011, '0, IO_IDLE);
    // words spread over the ram, read back to back
    add_row(OP_WR, 32'h000, 3'b011, '0, '0);
    add_row(OP_WR, 32'h004, 3'b011, '0, '0);
    add_row(OP_WR, 32'h040, 3'b011, '0, '0);
    add_row(OP_WR, 32'h3fc, 3'b011, '0, '0);
    add_row(OP_RD, 32'h000, 3'b011, '0, '0);
    add_row(OP_RD, 32'h004, 3'b011, '0, '0);
    add_row(OP_RD, 32'h040, 3'b011, '0, '0);
    add_row(OP_RD, 32'h3fc, 3'b011, '0, '0);
    // some lanes forced negative so sign extension shows
    add_row(OP_WR, 32'h010, 3'b011, 32'h0080_0080, '0);
    add_row(OP_WR, 32'h014, 3'b011, 32'h0000_8000, '0);
    // narrow writes touch only their own lanes
    add_row(OP_WR, 32'h011, 3'b001, '0, '0);
    add_row(OP_WR, 32'h016, 3'b010, '0, '0);
    add_row(OP_RD, 32'h010, 3'b011, '0, '0);
    add_row(OP_RD, 32'h014, 3'b011, '0, '0);
    for (int off = 0; off < 4; off++) begin
      add_row(OP_RD, 32'h010 + off, 3'b001, '0, '0);
      add_row(OP_RD, 32'h010 + off, 3'b101, '0, '0);
    end
    for (int off = 0; off < 4; off += 2) begin
      add_row(OP_RD, 32'h014 + off, 3'b010, '0, '0);
      add_row(OP_RD, 32'h014 + off, 3'b110, '0, '0);
    end
    // leds off until written, low nibble shows a cycle later
    add_row(OP_LED, '0, '0, '0, 32'hf);
    add_row(OP_WR, ADDR_LED, 3'b011, 32'h0000_00a5, '0);
    add_row(OP_LED, '0, '0, '0, 32'h5);
    // byte in flight reads back and goes out lsb first
    add_row(OP_WR, ADDR_UART_OUT, 3'b001, 32'h0000_005a, '0);
    add_row(OP_RD, ADDR_UART_OUT, 3'b011, '0, 32'h0000_005a);
    add_row(OP_FRAME, '0, '0, '0, 32'h0000_005a);
    // eleven bit times after the write the frame is over
    add_row(OP_WAIT, '0, '0, CLKS_PER_BIT, '0);
    add_row(OP_RD, ADDR_UART_OUT, 3'b011, '0, IO_IDLE);
    // loopback delivers the same byte, one read clears it
    add_row(OP_POLL, ADDR_UART_IN, 3'b011, '0, 32'h0000_005a);
    add_row(OP_RD, ADDR_UART_IN, 3'b011, '0, IO_IDLE);
  endtask

  initial begin
    rst_n     = 1'b0;
    idle_inputs();
    lcg_state = 32'd75;
    err_cnt   = 0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    pend_rd   = 1'b0;
    build_table();
    tbl_ready = 1'b1;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    foreach (tbl[i]) begin
      run_entry(i);
    end
    // last read of the table
    @(negedge clk);
    finish_pending();
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             tbl.size(), pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // four cycles per row, three uart frames and a margin
  initial begin
    int limit;
    wait (tbl_ready);
    limit = tbl.size() * 4 + 3 * FRAME_CLKS + 200;
    repeat (limit) @(posedge clk);
    $display("watchdog: run still going after %0d cycles, stopping", limit);
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== compile.f ====
common/ramio_pkg.sv
ramio/ram_bank.sv
ramio/ramio.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/ramio_top.sv
verification/tb_ramio.sv

// ==== Makefile ====
# verilator build, run and lint for the ramio testbench

VERILATOR  ?= verilator
TOP        ?= tb_ramio
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
FAIL_MSG   ?= Verification failed

SHELL := /bin/bash

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported failure, see $(LOG)"; \
	  exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
